/* src.f */
+incdir+source
source/wb_bank_pkg.sv
source/wb_access_decode.sv
source/bank_reg_cell.sv
source/bank_read_mux.sv
source/wb_reg_bank.sv
verification/wb_reg_bank_tb.sv

/* Makefile */
# Verilator build and run of the Wishbone register bank testbench

VERILATOR ?= verilator
TOP       ?= wb_reg_bank_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The simulator exit status carries pass or fail
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verification/wb_reg_bank_tb.sv */
// Table-driven testbench for the Wishbone register bank; run it as the simulation top level
`timescale 1ns/10ps

`include "wb_bank_macros.svh"

module wb_reg_bank_tb;

  import wb_bank_pkg::*;

  localparam int ADR_W     = `WB_BANK_ADDR_WIDTH;
  localparam int REGS      = `WB_BANK_REG_COUNT;
  localparam int LANES     = `WB_BANK_LANE_COUNT;
  localparam int LANE_W    = `WB_BANK_DATA_WIDTH / `WB_BANK_LANE_COUNT;
  localparam int RESET_CYC = 8;
  localparam int MARGIN    = 32;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_CLEAR} op_t;
  typedef enum logic {RESP_ACK, RESP_ERR} resp_t;

  // One row of the stimulus table
  typedef struct packed {
    op_t              op;
    logic [ADR_W-1:0] adr;
    lane_en_t         sel;
    bank_word_t       data;
    logic             rand_data;
    resp_t            resp;
    logic             from_model;
    bank_word_t       exp_data;
  } entry_t;

  logic             clk;
  logic             reset_n;
  logic             clear;
  logic             cyc;
  logic             stb;
  logic             we;
  logic [ADR_W-1:0] adr;
  lane_en_t         sel;
  bank_word_t       dat_w;
  bank_word_t       dat_r;
  logic             ack;
  logic             err;

  entry_t      stim_table [$];
  bank_word_t  model [REGS];
  bank_word_t  last_read;
  logic [15:0] lfsr_state;
  int          cycle_count   = 0;
  int          timeout_limit = 0;

  wb_reg_bank wb_reg_bank_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .clear   (clear),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .sel     (sel),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .err     (err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Run limit scales with the table length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      stop_on_error($sformatf("timeout: no progress after %0d cycles", cycle_count));
    end
  end

  // 16-bit Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic next_random_word(output bank_word_t w);
    w = '0;
    for (int b = 0; b < `WB_BANK_DATA_WIDTH; b++) begin
      w = {w[`WB_BANK_DATA_WIDTH-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic [ADR_W-1:0] word_adr(input int r);
    return ADR_W'(r * LANES);
  endfunction

  function automatic int word_index(input logic [ADR_W-1:0] a);
    return int'(a) / LANES;
  endfunction

  // Enabled lanes take the new byte, the rest keep the old one
  function automatic bank_word_t apply_lanes(input bank_word_t old, input bank_word_t d,
                                             input lane_en_t s);
    bank_word_t w;
    w = old;
    for (int l = 0; l < LANES; l++) begin
      if (s[l]) w[l*LANE_W +: LANE_W] = d[l*LANE_W +: LANE_W];
    end
    return w;
  endfunction

  task automatic add_row(input op_t op, input logic [ADR_W-1:0] a, input lane_en_t s,
                         input bank_word_t d, input logic rnd, input resp_t r,
                         input logic fm, input bank_word_t x);
    entry_t e;
    e = '{op: op, adr: a, sel: s, data: d, rand_data: rnd, resp: r, from_model: fm,
          exp_data: x};
    stim_table.push_back(e);
  endtask

  task automatic build_table();
    lane_en_t bad_lanes [6];
    bad_lanes = '{4'b0000, 4'b0101, 4'b0110, 4'b0111, 4'b1010, 4'b1110};
    // Registers come out of reset as zero
    for (int r = 0; r < REGS; r++) begin
      add_row(OP_READ, word_adr(r), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, '0);
    end
    // Random word writes, then read everything back
    for (int r = 0; r < REGS; r++) begin
      add_row(OP_WRITE, word_adr(r), 4'hF, '0, 1'b1, RESP_ACK, 1'b0, '0);
    end
    for (int r = 0; r < REGS; r++) begin
      add_row(OP_READ, word_adr(r), 4'hF, '0, 1'b0, RESP_ACK, 1'b1, '0);
    end
    add_row(OP_WRITE, word_adr(5), 4'hF, '0, 1'b1, RESP_ACK, 1'b0, '0);
    for (int r = 4; r < 7; r++) begin
      add_row(OP_READ, word_adr(r), 4'hF, '0, 1'b0, RESP_ACK, 1'b1, '0);
    end
    // Byte and halfword lanes on register 2
    add_row(OP_WRITE, word_adr(2), 4'hF, 32'h11223344, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_WRITE, word_adr(2), 4'b0010, 32'hAABBCCDD, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(2), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, 32'h1122CC44);
    add_row(OP_WRITE, word_adr(2), 4'b1100, 32'h55667788, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(2), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, 32'h5566CC44);
    add_row(OP_WRITE, word_adr(2), 4'b1000, 32'h99000000, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(2), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, 32'h9966CC44);
    add_row(OP_WRITE, word_adr(2), 4'b0001, 32'h000000EE, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(2), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, 32'h9966CCEE);
    add_row(OP_WRITE, word_adr(2), 4'b0011, 32'hFFFF1234, 1'b0, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(2), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, 32'h99661234);
    // Illegal lanes and missing registers answer err and change nothing
    foreach (bad_lanes[i]) begin
      add_row(OP_WRITE, word_adr(1), bad_lanes[i], 32'hDEADBEEF, 1'b0, RESP_ERR, 1'b0, '0);
    end
    add_row(OP_WRITE, word_adr(REGS), 4'hF, 32'hCAFEF00D, 1'b0, RESP_ERR, 1'b0, '0);
    add_row(OP_WRITE, word_adr(15), 4'hF, 32'h0BADC0DE, 1'b0, RESP_ERR, 1'b0, '0);
    add_row(OP_READ, word_adr(REGS + 3), 4'hF, '0, 1'b0, RESP_ERR, 1'b0, '0);
    add_row(OP_READ, word_adr(0), 4'b0110, '0, 1'b0, RESP_ERR, 1'b0, '0);
    for (int r = 0; r < REGS; r++) begin
      add_row(OP_READ, word_adr(r), 4'hF, '0, 1'b0, RESP_ACK, 1'b1, '0);
    end
    // Clear, then the bank is still writable
    add_row(OP_CLEAR, '0, '0, '0, 1'b0, RESP_ACK, 1'b0, '0);
    for (int r = 0; r < REGS; r++) begin
      add_row(OP_READ, word_adr(r), 4'hF, '0, 1'b0, RESP_ACK, 1'b0, '0);
    end
    add_row(OP_WRITE, word_adr(7), 4'hF, '0, 1'b1, RESP_ACK, 1'b0, '0);
    add_row(OP_READ, word_adr(7), 4'hF, '0, 1'b0, RESP_ACK, 1'b1, '0);
  endtask

  task automatic apply_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    assert (!ack && !err) else stop_on_error("response seen while no access was pending");
    for (int r = 0; r < REGS; r++) model[r] = '0;
  endtask

  // One Wishbone classic access with the response checked cycle by cycle
  task automatic run_access(input int idx, input entry_t e);
    logic       exp_ack;
    bank_word_t expected;
    exp_ack = (e.resp == RESP_ACK);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= (e.op == OP_WRITE);
    adr   <= e.adr;
    sel   <= e.sel;
    dat_w <= e.data;
    @(negedge clk);
    assert (!ack && !err) else
      stop_on_error($sformatf("entry %0d answered in the same cycle as the strobe", idx));
    @(posedge clk);
    @(negedge clk);
    assert (!(ack && err)) else
      stop_on_error($sformatf("entry %0d got ack and err together", idx));
    assert (ack || err) else
      stop_on_error($sformatf("entry %0d got no response one cycle after the strobe", idx));
    assert (ack == exp_ack) else
      stop_on_error($sformatf("FAILED ack in entry %0d: expected %h, got %h", idx, exp_ack, ack));
    assert (err == !exp_ack) else
      stop_on_error($sformatf("FAILED err in entry %0d: expected %h, got %h", idx, !exp_ack, err));
    if (e.op == OP_READ && exp_ack) begin
      expected = e.from_model ? model[word_index(e.adr)] : e.exp_data;
      assert (dat_r == expected) else
        stop_on_error($sformatf("FAILED dat_r in entry %0d: expected %h, got %h",
                                idx, expected, dat_r));
      last_read = expected;
    end else begin
      // Read data only moves on a legal read
      assert (dat_r == last_read) else
        stop_on_error($sformatf("FAILED dat_r in entry %0d: expected %h, got %h",
                                idx, last_read, dat_r));
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    assert (!ack && !err) else
      stop_on_error($sformatf("entry %0d kept its response for more than one cycle", idx));
    if (e.op == OP_WRITE && exp_ack) begin
      model[word_index(e.adr)] = apply_lanes(model[word_index(e.adr)], e.data, e.sel);
    end
  endtask

  initial begin
    entry_t e;
    reset_n    = 1'b0;
    clear      = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    sel        = '0;
    dat_w      = '0;
    last_read  = '0;
    lfsr_state = 16'd55536;
    for (int r = 0; r < REGS; r++) model[r] = '0;
    build_table();
    timeout_limit = 4 * stim_table.size() + RESET_CYC + MARGIN;

    repeat (RESET_CYC) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    assert (!ack && !err) else stop_on_error("response active right after reset");
    assert (dat_r == '0) else
      stop_on_error($sformatf("FAILED dat_r after reset: expected %h, got %h", 32'h0, dat_r));

    for (int i = 0; i < stim_table.size(); i++) begin
      e = stim_table[i];
      if (e.rand_data) next_random_word(e.data);
      if (e.op == OP_CLEAR) apply_clear();
      else run_access(i, e);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule : wb_reg_bank_tb

/* source/wb_reg_bank.sv */
// Top level of the Wishbone classic register bank: decoder, register cells and read multiplexer
`timescale 1ns/10ps

`include "wb_bank_macros.svh"

module wb_reg_bank (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           clear,
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [`WB_BANK_ADDR_WIDTH-1:0] adr,
  input  wb_bank_pkg::lane_en_t          sel,
  input  wb_bank_pkg::bank_word_t        dat_w,
  output wb_bank_pkg::bank_word_t        dat_r,
  output logic                           ack,
  output logic                           err
);

  import wb_bank_pkg::*;

  reg_sel_t   wr_sel;
  reg_sel_t   rd_sel;
  logic       rd_capture;
  bank_word_t reg_data [`WB_BANK_REG_COUNT];

  // Handshake, classification and selects
  wb_access_decode wb_access_decode_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .sel        (sel),
    .wr_sel     (wr_sel),
    .rd_sel     (rd_sel),
    .rd_capture (rd_capture),
    .ack        (ack),
    .err        (err)
  );

  // Scratch registers, bus data and lanes shared by all
  for (genvar i = 0; i < `WB_BANK_REG_COUNT; i++) begin : g_cell
    bank_reg_cell #(
      .RESET_VALUE (bank_word_t'(0))
    ) bank_reg_cell_inst (
      .clk      (clk),
      .reset_n  (reset_n),
      .clear    (clear),
      .wen      (wr_sel[i]),
      .lane_en  (sel),
      .data_in  (dat_w),
      .data_out (reg_data[i])
    );
  end

  // Read path
  bank_read_mux bank_read_mux_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_capture (rd_capture),
    .rd_sel     (rd_sel),
    .reg_data   (reg_data),
    .dat_r      (dat_r)
  );

endmodule : wb_reg_bank

/* source/bank_read_mux.sv */
// One-hot read multiplexer across the bank registers and the registered Wishbone read data
`timescale 1ns/10ps

`include "wb_bank_macros.svh"

module bank_read_mux (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    rd_capture,
  input  wb_bank_pkg::reg_sel_t   rd_sel,
  input  wb_bank_pkg::bank_word_t reg_data [`WB_BANK_REG_COUNT],
  output wb_bank_pkg::bank_word_t dat_r
);

  import wb_bank_pkg::*;

  bank_word_t mux_word;

  // AND-OR selection, valid only while rd_sel is one-hot
  always_comb begin
    mux_word = '0;
    for (int i = 0; i < `WB_BANK_REG_COUNT; i++) begin
      mux_word = mux_word | (reg_data[i] & {`WB_BANK_DATA_WIDTH{rd_sel[i]}});
    end
  end

  // Holds the last legal read until the next one
  always_ff @(posedge clk, negedge reset_n) begin
    if (~reset_n) begin
      dat_r <= '0;
    end else if (rd_capture) begin
      dat_r <= mux_word;
    end
  end

  // Decoder select must be one-hot or idle
  a_rd_sel_onehot0 : assert property (
    @(posedge clk) disable iff (!reset_n)
    $onehot0(rd_sel)
  ) else $error("read select not one-hot: %h", rd_sel);

endmodule : bank_read_mux

/* source/bank_reg_cell.sv */
// One scratch register of the bank with byte-lane writes, synchronous clear and async reset
`timescale 1ns/10ps

`include "wb_bank_macros.svh"

module bank_reg_cell #(
  parameter wb_bank_pkg::bank_word_t RESET_VALUE = '0
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    clear,
  input  logic                    wen,
  input  wb_bank_pkg::lane_en_t   lane_en,
  input  wb_bank_pkg::bank_word_t data_in,
  output wb_bank_pkg::bank_word_t data_out
);

  import wb_bank_pkg::*;

  localparam int LANE_BITS = `WB_BANK_DATA_WIDTH / `WB_BANK_LANE_COUNT;

  bank_word_t cell_q;
  bank_word_t merged;

  // New byte where the lane is enabled, old byte elsewhere
  always_comb begin
    for (int lane = 0; lane < `WB_BANK_LANE_COUNT; lane++) begin
      merged[lane*LANE_BITS +: LANE_BITS] = lane_en[lane] ?
          data_in[lane*LANE_BITS +: LANE_BITS] :
          cell_q[lane*LANE_BITS +: LANE_BITS];
    end
  end

  // clear wins over a write in the same cycle
  always_ff @(posedge clk, negedge reset_n) begin
    if (~reset_n) begin
      cell_q <= RESET_VALUE;
    end else if (clear) begin
      cell_q <= '0;
    end else if (wen) begin
      cell_q <= merged;
    end
  end

  assign data_out = cell_q;

  // Decoder gives a single-cycle write strobe per access
  a_wen_single_cycle : assert property (
    @(posedge clk) disable iff (!reset_n)
    wen |=> !wen
  ) else $error("write enable held for more than one cycle");

endmodule : bank_reg_cell

/* source/wb_access_decode.sv */
// Wishbone classic front end of the register bank: classifies each access and answers ack or err
`timescale 1ns/10ps

`include "wb_bank_macros.svh"

module wb_access_decode (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [`WB_BANK_ADDR_WIDTH-1:0] adr,
  input  wb_bank_pkg::lane_en_t          sel,
  output wb_bank_pkg::reg_sel_t          wr_sel,
  output wb_bank_pkg::reg_sel_t          rd_sel,
  output logic                           rd_capture,
  output logic                           ack,
  output logic                           err
);

  import wb_bank_pkg::*;

  // Low address bits select a byte inside the word
  localparam int LANE_ADDR_BITS = $clog2(`WB_BANK_LANE_COUNT);

  access_t    acc_class;
  reg_index_t word_idx;
  logic       idx_in_range;
  logic       start;
  logic       legal;
  logic       wr_en;
  logic       rd_en;

  // A new access is only taken while no response is showing
  assign start = cyc & stb & ~ack & ~err;

  // Lane pattern class
  always_comb begin
    case (sel)
      4'b0001,
      4'b0010,
      4'b0100,
      4'b1000: acc_class = ACC_BYTE;
      4'b0011,
      4'b1100: acc_class = ACC_HALFWORD;
      4'b1111: acc_class = ACC_WORD;
      default: acc_class = ACC_BAD;
    endcase
  end

  // Word slot from the byte address; byte position comes from sel
  assign word_idx     = adr[`WB_BANK_ADDR_WIDTH-1:LANE_ADDR_BITS];
  assign idx_in_range = (int'(word_idx) < `WB_BANK_REG_COUNT);

  assign legal = idx_in_range & (acc_class != ACC_BAD);

  // Enables for the select decoders
  assign wr_en = start & legal & we;
  assign rd_en = start & legal & ~we;

  // Decoders with enable, one-hot only for a legal access
  assign wr_sel = reg_sel_t'(wr_en) << word_idx;
  assign rd_sel = reg_sel_t'(rd_en) << word_idx;

  // Read data gets loaded at the same edge that raises ack
  assign rd_capture = rd_en;

  // Response, one cycle after the access is first seen
  always_ff @(posedge clk, negedge reset_n) begin
    if (~reset_n) begin
      ack <= 1'b0;
      err <= 1'b0;
    end else begin
      ack <= start & legal;
      err <= start & ~legal;
    end
  end

  // Never both responses at once
  a_ack_err_exclusive : assert property (
    @(posedge clk) disable iff (!reset_n)
    !(ack && err)
  ) else $error("ack and err high together");

  // No response without a strobe in the cycle before
  a_resp_needs_stb : assert property (
    @(posedge clk) disable iff (!reset_n)
    !stb |=> !(ack || err)
  ) else $error("response without a preceding strobe");

endmodule : wb_access_decode

/* source/wb_bank_pkg.sv */
// Shared types for the Wishbone register bank, imported by every RTL module of the bank
`include "wb_bank_macros.svh"

package wb_bank_pkg;

  // One register or bus data word
  typedef logic [`WB_BANK_DATA_WIDTH-1:0] bank_word_t;

  // Wishbone sel lanes, one bit per byte
  typedef logic [`WB_BANK_LANE_COUNT-1:0] lane_en_t;

  // Word index taken from the byte address
  // Wide enough to cover every word slot, implemented or not
  typedef logic [`WB_BANK_ADDR_WIDTH-$clog2(`WB_BANK_LANE_COUNT)-1:0] reg_index_t;

  // One bit per implemented register
  typedef logic [`WB_BANK_REG_COUNT-1:0] reg_sel_t;

  // Lane pattern class, in the order of the store sizes
  typedef enum logic [1:0] {
    ACC_BYTE,
    ACC_HALFWORD,
    ACC_WORD,
    ACC_BAD
  } access_t;

endpackage : wb_bank_pkg

/* source/wb_bank_macros.svh */
// Sizing constants for the Wishbone register bank, included by the package, the RTL and the testbench
`ifndef WB_BANK_MACROS_SVH
`define WB_BANK_MACROS_SVH

// Number of implemented scratch registers
`define WB_BANK_REG_COUNT 8

// Register and bus data width in bits
`define WB_BANK_DATA_WIDTH 32

// Wishbone byte address width
// 16 word slots, only the first WB_BANK_REG_COUNT exist
`define WB_BANK_ADDR_WIDTH 6

// Byte lanes on the data bus, one sel bit each
`define WB_BANK_LANE_COUNT 4

`endif
